/* design/mailbox_pkg.sv */
/*
 * mailbox package
 * wishbone data and address types, request and response bundles,
 * register map and status word bit positions
 */

package mailbox_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] wb_data_t;  // wishbone data word
  typedef logic [1:0]  wb_adr_t;   // word address inside one port

  // master to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  localparam wb_adr_t ADR_DATA      = 2'd0;
  localparam wb_adr_t ADR_STATUS    = 2'd1;
  localparam wb_adr_t ADR_THRESHOLD = 2'd2;  // consumer side only

  // fill level sits in bits 15..0 of the status word
  localparam int STAT_FULL_BIT  = 16;
  localparam int STAT_EMPTY_BIT = 17;
  localparam int STAT_IRQ_BIT   = 18;

endpackage

/* design/reg_sp_rf.sv */
/*
 * register file memory
 * clocked write on port a, combinational read on port b
 */

`timescale 1ns/1ns

module reg_sp_rf #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 3
) (
  input  logic                    clk,
  input  logic                    port_a_write_en,
  input  logic [ADDR_WIDTH_P-1:0] port_a_address,
  input  logic [DATA_WIDTH_P-1:0] port_a_data_in,
  input  logic [ADDR_WIDTH_P-1:0] port_b_address,
  output logic [DATA_WIDTH_P-1:0] port_b_data_out
);

  localparam int DEPTH = 2 ** ADDR_WIDTH_P;

  typedef logic [DATA_WIDTH_P-1:0] word_t;

  word_t mem [DEPTH];  // contents undefined until written

  // write port
  always_ff @(posedge clk) begin
    if (port_a_write_en) begin
      mem[port_a_address] <= port_a_data_in;
    end
  end

  assign port_b_data_out = mem[port_b_address];  // async read

endmodule

/* design/synchronous_fifo_register.sv */
/*
 * synchronous fifo over a register file
 * wrapping read and write pointers, fill level, full and empty flags
 */

`timescale 1ns/1ns

module synchronous_fifo_register #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 3
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    ing_enable,
  input  logic [DATA_WIDTH_P-1:0] ing_data,
  output logic                    ing_full,

  input  logic                    egr_enable,
  output logic [DATA_WIDTH_P-1:0] egr_data,
  output logic                    egr_empty,

  output logic [ADDR_WIDTH_P:0]   sr_fill_level
);

  typedef logic [ADDR_WIDTH_P-1:0] ptr_t;   // wraps at depth
  typedef logic [ADDR_WIDTH_P:0]   level_t; // one extra bit for full

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  level_t fill_q;
  logic   empty_q;
  logic   do_push;
  logic   do_pop;

  // requests are dropped when the fifo can't take them
  assign do_push = ing_enable && !ing_full;
  assign do_pop  = egr_enable && !egr_empty;

  assign ing_full      = fill_q[ADDR_WIDTH_P];  // msb set only at depth
  assign egr_empty     = empty_q;
  assign sr_fill_level = fill_q;

  //////////////////////////////////////////////////////////////////////
  // pointers and level
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill_q  <= '0;
      empty_q <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // push and pop together keep the level
      if (do_push && !do_pop) begin
        fill_q  <= fill_q + 1'b1;
        empty_q <= 1'b0;
      end else if (do_pop && !do_push) begin
        fill_q <= fill_q - 1'b1;
        if (fill_q == level_t'(1)) begin
          empty_q <= 1'b1;  // last word leaving
        end
      end
    end
  end

  reg_sp_rf #(
    .DATA_WIDTH_P    (DATA_WIDTH_P),
    .ADDR_WIDTH_P    (ADDR_WIDTH_P)
  ) rf_i0 (
    .clk             (clk),
    .port_a_write_en (do_push),
    .port_a_address  (wr_ptr),
    .port_a_data_in  (ing_data),
    .port_b_address  (rd_ptr),
    .port_b_data_out (egr_data)   // head word with no latency
  );

endmodule

/* design/wb_push_port.sv */
/*
 * producer wishbone classic slave
 * DATA write pushes into the fifo, stalls while full
 * STATUS read returns level, full and empty
 */

`timescale 1ns/1ns

module wb_push_port #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 3
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mailbox_pkg::wb_req_t    wb_req,
  output mailbox_pkg::wb_rsp_t    wb_rsp,
  output logic                    ing_enable,
  output logic [DATA_WIDTH_P-1:0] ing_data,
  input  logic                    ing_full,
  input  logic [ADDR_WIDTH_P:0]   sr_fill_level
);

  import mailbox_pkg::*;

  logic     ack_q;
  wb_data_t dat_q;
  logic     req_valid;
  logic     data_wr;
  logic     ack_d;
  wb_data_t rd_word;
  wb_data_t status_word;

  // a cycle with ack already up is not a new request
  assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;
  assign data_wr   = req_valid && wb_req.we && (wb_req.adr == ADR_DATA);

  // push on the same edge that registers the ack
  assign ing_enable = data_wr && !ing_full;
  assign ing_data   = wb_req.dat[DATA_WIDTH_P-1:0];  // high bits dropped

  // data writes wait for room, everything else answers at once
  assign ack_d = data_wr ? !ing_full : req_valid;

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    status_word                   = '0;
    status_word[ADDR_WIDTH_P:0]   = sr_fill_level;
    status_word[STAT_FULL_BIT]    = ing_full;
    status_word[STAT_EMPTY_BIT]   = (sr_fill_level == '0);  // no irq here
  end

  always_comb begin
    rd_word = '0;  // unused addresses and DATA read as zero
    if (!wb_req.we && wb_req.adr == ADR_STATUS) begin
      rd_word = status_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ack_d) begin
      dat_q <= rd_word;  // captured with the ack
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

endmodule

/* design/wb_pop_port.sv */
/*
 * consumer wishbone classic slave
 * DATA read pops the head word, stalls while empty
 * STATUS, THRESHOLD register and level interrupt
 */

`timescale 1ns/1ns

module wb_pop_port #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 3
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mailbox_pkg::wb_req_t    wb_req,
  output mailbox_pkg::wb_rsp_t    wb_rsp,
  output logic                    egr_enable,
  input  logic [DATA_WIDTH_P-1:0] egr_data,
  input  logic                    egr_empty,
  input  logic [ADDR_WIDTH_P:0]   sr_fill_level,
  output logic                    irq
);

  import mailbox_pkg::*;

  typedef logic [ADDR_WIDTH_P:0] level_t;  // same range as fill level

  logic     ack_q;
  wb_data_t dat_q;
  level_t   threshold_q;
  logic     irq_q;
  logic     req_valid;
  logic     data_rd;
  logic     thr_wr;
  logic     ack_d;
  wb_data_t head_word;
  wb_data_t status_word;
  wb_data_t rd_word;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;
  assign data_rd   = req_valid && !wb_req.we && (wb_req.adr == ADR_DATA);
  assign thr_wr    = req_valid && wb_req.we && (wb_req.adr == ADR_THRESHOLD);

  assign egr_enable = data_rd && !egr_empty;  // pop with the ack edge

  // reads of DATA hold off until a word is there
  assign ack_d = data_rd ? !egr_empty : req_valid;

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    head_word                   = '0;
    head_word[DATA_WIDTH_P-1:0] = egr_data;  // zero extend
  end

  always_comb begin
    status_word                 = '0;
    status_word[ADDR_WIDTH_P:0] = sr_fill_level;
    status_word[STAT_FULL_BIT]  = sr_fill_level[ADDR_WIDTH_P];
    status_word[STAT_EMPTY_BIT] = egr_empty;
    status_word[STAT_IRQ_BIT]   = irq_q;
  end

  always_comb begin
    rd_word = '0;  // writes and unused addresses
    if (!wb_req.we) begin
      case (wb_req.adr)
        ADR_DATA:      rd_word = head_word;
        ADR_STATUS:    rd_word = status_word;
        ADR_THRESHOLD: rd_word[ADDR_WIDTH_P:0] = threshold_q;
        default:       rd_word = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q       <= 1'b0;
      threshold_q <= '0;
      irq_q       <= 1'b0;
    end else begin
      ack_q <= ack_d;
      if (thr_wr) begin
        threshold_q <= wb_req.dat[ADDR_WIDTH_P:0];  // upper bits ignored
      end
      // zero threshold disables the interrupt
      irq_q <= (threshold_q != '0) && (sr_fill_level >= threshold_q);
    end
  end

  always_ff @(posedge clk) begin
    if (ack_d) begin
      dat_q <= rd_word;  // head word latched as it pops
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;
  assign irq        = irq_q;

endmodule

/* design/wb_mailbox.sv */
/*
 * mailbox top level
 * producer port, fifo and consumer port
 */

`timescale 1ns/1ns

module wb_mailbox #(
  parameter int DATA_WIDTH_P = 16,  // at most 32
  parameter int ADDR_WIDTH_P = 3    // depth 2**ADDR_WIDTH_P
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mailbox_pkg::wb_req_t push_req,
  output mailbox_pkg::wb_rsp_t push_rsp,
  input  mailbox_pkg::wb_req_t pop_req,
  output mailbox_pkg::wb_rsp_t pop_rsp,
  output logic                 irq
);

  // producer to fifo
  logic                    ing_enable;
  logic [DATA_WIDTH_P-1:0] ing_data;
  logic                    ing_full;

  // fifo to consumer
  logic                    egr_enable;
  logic [DATA_WIDTH_P-1:0] egr_data;
  logic                    egr_empty;

  logic [ADDR_WIDTH_P:0]   sr_fill_level;  // seen by both ports

  wb_push_port #(
    .DATA_WIDTH_P  (DATA_WIDTH_P),
    .ADDR_WIDTH_P  (ADDR_WIDTH_P)
  ) push_port_i0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req        (push_req),
    .wb_rsp        (push_rsp),
    .ing_enable    (ing_enable),
    .ing_data      (ing_data),
    .ing_full      (ing_full),
    .sr_fill_level (sr_fill_level)
  );

  synchronous_fifo_register #(
    .DATA_WIDTH_P  (DATA_WIDTH_P),
    .ADDR_WIDTH_P  (ADDR_WIDTH_P)
  ) fifo_i0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ing_enable    (ing_enable),
    .ing_data      (ing_data),
    .ing_full      (ing_full),
    .egr_enable    (egr_enable),
    .egr_data      (egr_data),
    .egr_empty     (egr_empty),
    .sr_fill_level (sr_fill_level)
  );

  wb_pop_port #(
    .DATA_WIDTH_P  (DATA_WIDTH_P),
    .ADDR_WIDTH_P  (ADDR_WIDTH_P)
  ) pop_port_i0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req        (pop_req),
    .wb_rsp        (pop_rsp),
    .egr_enable    (egr_enable),
    .egr_data      (egr_data),
    .egr_empty     (egr_empty),
    .sr_fill_level (sr_fill_level),
    .irq           (irq)
  );

endmodule

/* test/wb_mailbox_assertions.sv */
/*
 * concurrent checks bound into the mailbox top level
 * one cycle acks that follow a strobe, fifo flag and level rules
 */

`timescale 1ns/1ns

module wb_mailbox_assertions #(
  parameter int ADDR_WIDTH_P = 3
) (
  input logic                  clk,
  input logic                  rst_n,
  input mailbox_pkg::wb_req_t  push_req,
  input mailbox_pkg::wb_rsp_t  push_rsp,
  input mailbox_pkg::wb_req_t  pop_req,
  input mailbox_pkg::wb_rsp_t  pop_rsp,
  input logic                  ing_full,
  input logic                  egr_empty,
  input logic [ADDR_WIDTH_P:0] sr_fill_level
);

  localparam int DEPTH = 2 ** ADDR_WIDTH_P;

  // ack is a single cycle pulse
  push_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    push_rsp.ack |=> !push_rsp.ack) else $error("push ack high two cycles running");
  pop_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    pop_rsp.ack |=> !pop_rsp.ack) else $error("pop ack high two cycles running");

  // no ack without a strobed cycle the cycle before
  push_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
    !(push_req.cyc && push_req.stb) |=> !push_rsp.ack)
    else $error("push ack without cyc and stb");
  pop_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
    !(pop_req.cyc && pop_req.stb) |=> !pop_rsp.ack)
    else $error("pop ack without cyc and stb");

  flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(ing_full && egr_empty)) else $error("fifo full and empty together");

  level_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(sr_fill_level) <= DEPTH) else $error("fill level above capacity");

endmodule

bind wb_mailbox wb_mailbox_assertions #(
  .ADDR_WIDTH_P  (ADDR_WIDTH_P)
) i_wb_mailbox_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .push_req      (push_req),
  .push_rsp      (push_rsp),
  .pop_req       (pop_req),
  .pop_rsp       (pop_rsp),
  .ing_full      (ing_full),
  .egr_empty     (egr_empty),
  .sr_fill_level (sr_fill_level)
);

/* test/tb_wb_mailbox.sv */
/*
 * testbench for the wishbone mailbox
 * bus tasks for both ports, reference queue, compare tasks,
 * directed tests, watchdog, clock and reset
 */

`timescale 1ns/1ns

module tb_wb_mailbox;

  import mailbox_pkg::*;

  localparam int DATA_WIDTH     = 16;
  localparam int ADDR_WIDTH     = 3;
  localparam int DEPTH          = 2 ** ADDR_WIDTH;
  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 5;   // inputs change this long after the edge
  localparam int RESET_CYCLES   = 10;
  localparam int STALL_WINDOW   = 6;   // cycles watched for a withheld ack
  localparam int NUM_ROUNDS     = 4;
  localparam int ROUND_WORDS    = 5;   // stays below depth
  localparam int NUM_ACCESSES   = 200; // upper count over all tests
  localparam int ACCESS_BOUND   = 16;  // cycles one access may take including stalls
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ACCESSES * ACCESS_BOUND;
  localparam logic [31:0] RANDOM_SEED = 32'h45cb_b1e6;
  localparam wb_data_t DATA_MASK = wb_data_t'((64'd1 << DATA_WIDTH) - 1);

  logic     clk;
  logic     rst_n;
  wb_req_t  push_req;
  wb_rsp_t  push_rsp;
  wb_req_t  pop_req;
  wb_rsp_t  pop_rsp;
  logic     irq;
  int       cycle_count = 0;
  wb_data_t ref_q [$];  // words still inside the fifo with the oldest first

  wb_mailbox #(
    .DATA_WIDTH_P (DATA_WIDTH),
    .ADDR_WIDTH_P (ADDR_WIDTH)
  ) i_wb_mailbox (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_req (push_req),
    .push_rsp (push_rsp),
    .pop_req  (pop_req),
    .pop_rsp  (pop_rsp),
    .irq      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_count);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // expected values and compares
  //////////////////////////////////////////////////////////////////////

  function automatic wb_data_t expected_status(input int level, input logic irq_bit);
    wb_data_t word;
    word                 = wb_data_t'(level);  // level in the low half
    word[STAT_FULL_BIT]  = (level == DEPTH);
    word[STAT_EMPTY_BIT] = (level == 0);
    word[STAT_IRQ_BIT]   = irq_bit;            // consumer side only
    return word;
  endfunction

  function automatic logic expected_irq(input int level, input int threshold);
    return (threshold != 0) && (level >= threshold);
  endfunction

  task automatic report_mismatch(input string what, input wb_data_t got,
                                 input wb_data_t expected);
    $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
    $display("Simulation failed");
    $fatal(1, "mismatch in %s", what);
  endtask

  task automatic compare_data(input wb_data_t got, input wb_data_t expected,
                              input string what);
    if (got !== expected) begin
      report_mismatch({what, " data"}, got, expected);
    end
  endtask

  task automatic compare_status(input wb_data_t got, input wb_data_t expected,
                                input string what);
    if (got !== expected) begin
      report_mismatch({what, " status"}, got, expected);
    end
  endtask

  task automatic compare_irq(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      report_mismatch({what, " irq"}, wb_data_t'(got), wb_data_t'(expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic drive_request(input logic on_pop, input logic we, input wb_adr_t adr,
                               input wb_data_t dat);
    wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    if (on_pop) pop_req = req;
    else push_req = req;
  endtask

  // hold until ack and then idle one cycle before the next access
  task automatic complete_request(input logic on_pop, output wb_data_t rdat);
    while ((on_pop ? pop_rsp.ack : push_rsp.ack) !== 1'b1) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    rdat = on_pop ? pop_rsp.dat : push_rsp.dat;
    if (on_pop) pop_req = '0;
    else push_req = '0;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic bus_access(input logic on_pop, input logic we, input wb_adr_t adr,
                            input wb_data_t wdat, output wb_data_t rdat);
    drive_request(on_pop, we, adr, wdat);
    complete_request(on_pop, rdat);
  endtask

  task automatic push_write(input wb_adr_t adr, input wb_data_t dat);
    wb_data_t ignored;
    bus_access(1'b0, 1'b1, adr, dat, ignored);
  endtask

  task automatic push_read(input wb_adr_t adr, output wb_data_t dat);
    bus_access(1'b0, 1'b0, adr, '0, dat);
  endtask

  task automatic pop_write(input wb_adr_t adr, input wb_data_t dat);
    wb_data_t ignored;
    bus_access(1'b1, 1'b1, adr, dat, ignored);
  endtask

  task automatic pop_read(input wb_adr_t adr, output wb_data_t dat);
    bus_access(1'b1, 1'b0, adr, '0, dat);
  endtask

  task automatic push_word(input wb_data_t word);
    push_write(ADR_DATA, word);
    ref_q.push_back(word & DATA_MASK);  // fifo keeps the low bits only
  endtask

  task automatic pop_and_check(input string what);
    wb_data_t got;
    pop_read(ADR_DATA, got);
    compare_data(got, ref_q.pop_front(), what);
  endtask

  task automatic check_both_status(input logic irq_exp, input string what);
    wb_data_t got;
    push_read(ADR_STATUS, got);
    compare_status(got, expected_status(ref_q.size(), 1'b0), {what, " push"});
    pop_read(ADR_STATUS, got);
    compare_status(got, expected_status(ref_q.size(), irq_exp), {what, " pop"});
  endtask

  // irq pin and status bit checked one cycle after the level settled
  task automatic check_irq_level(input int threshold, input string what);
    wb_data_t got;
    logic     irq_exp;
    irq_exp = expected_irq(ref_q.size(), threshold);
    @(posedge clk);
    #DRIVE_DELAY;
    compare_irq(irq, irq_exp, what);
    pop_read(ADR_STATUS, got);
    compare_status(got, expected_status(ref_q.size(), irq_exp), what);
  endtask

  task automatic expect_no_ack(input logic on_pop, input string what);
    repeat (STALL_WINDOW) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if ((on_pop ? pop_rsp.ack : push_rsp.ack) !== 1'b0) begin
        $display("error at %0t ns: %s was acknowledged while it should stall", $time, what);
        $display("Simulation failed");
        $fatal(1, "ack during stall");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_both_status(1'b0, "reset");
    compare_irq(irq, 1'b0, "reset");
  endtask

  task automatic test_ordering();
    wb_data_t got;
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      for (int i = 0; i < ROUND_WORDS; i++) begin
        push_word($urandom());
        push_read(ADR_STATUS, got);
        compare_status(got, expected_status(ref_q.size(), 1'b0), "ordering fill");
      end
      while (ref_q.size() > 0) pop_and_check("ordering");
    end
  endtask

  task automatic test_full_stall();
    wb_data_t got;
    wb_data_t late_word;
    for (int i = 0; i < DEPTH; i++) push_word($urandom());
    check_both_status(1'b0, "full");
    late_word = $urandom();
    drive_request(1'b0, 1'b1, ADR_DATA, late_word);  // held while full
    expect_no_ack(1'b0, "write to the full fifo");
    pop_and_check("full stall");                     // frees one slot
    complete_request(1'b0, got);
    ref_q.push_back(late_word & DATA_MASK);
    check_both_status(1'b0, "full again");
    while (ref_q.size() > 0) pop_and_check("full drain");
  endtask

  task automatic test_empty_stall();
    wb_data_t got;
    wb_data_t word;
    word = $urandom();
    drive_request(1'b1, 1'b0, ADR_DATA, '0);  // read waits for a word
    expect_no_ack(1'b1, "read of the empty fifo");
    push_write(ADR_DATA, word);
    complete_request(1'b1, got);
    compare_data(got, word & DATA_MASK, "empty stall");
    check_both_status(1'b0, "empty again");
  endtask

  task automatic test_threshold_irq();
    wb_data_t got;
    int       threshold;
    threshold = 3;
    pop_write(ADR_THRESHOLD, wb_data_t'(threshold));
    pop_read(ADR_THRESHOLD, got);
    compare_status(got, wb_data_t'(threshold), "threshold readback");
    for (int i = 0; i < 5; i++) begin
      push_word($urandom());
      check_irq_level(threshold, "threshold rising");
    end
    threshold = 0;  // disables irq at any level
    pop_write(ADR_THRESHOLD, '0);
    check_irq_level(threshold, "threshold cleared");
    threshold = 2;
    pop_write(ADR_THRESHOLD, wb_data_t'(threshold));
    while (ref_q.size() > 0) begin
      pop_and_check("threshold drain");
      check_irq_level(threshold, "threshold falling");
    end
    pop_write(ADR_THRESHOLD, '0);
  endtask

  task automatic test_unused_access();
    wb_data_t got;
    push_word($urandom());
    push_word($urandom());
    push_write(ADR_STATUS, '1);
    pop_write(ADR_STATUS, '1);
    pop_write(ADR_DATA, '1);  // consumer DATA is read only
    for (int a = 2; a < 4; a++) begin
      push_write(wb_adr_t'(a), $urandom());
      push_read(wb_adr_t'(a), got);
      compare_status(got, '0, "unused push address");
    end
    pop_write(wb_adr_t'(3), '1);
    pop_read(wb_adr_t'(3), got);
    compare_status(got, '0, "unused pop address");
    check_both_status(1'b0, "after unused");
    while (ref_q.size() > 0) pop_and_check("unused drain");
  endtask

  initial begin
    void'($urandom(RANDOM_SEED));
    rst_n    = 1'b0;
    push_req = '0;
    pop_req  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    test_reset_state();
    test_ordering();
    test_full_stall();
    test_empty_stall();
    test_threshold_irq();
    test_unused_access();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* files.f */
design/mailbox_pkg.sv
design/reg_sp_rf.sv
design/synchronous_fifo_register.sv
design/wb_push_port.sv
design/wb_pop_port.sv
design/wb_mailbox.sv
test/wb_mailbox_assertions.sv
test/tb_wb_mailbox.sv

/* Makefile */
# verilator build and run of the mailbox testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_mailbox
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "sim: run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
